// File: files.f
hazardPkg.sv
stageIf.sv
pipeHistory.sv
regHazardUnit.sv
memHazardUnit.sv
issueControl.sv
hazardTop.sv
hazardTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= hazardTb
SEED      ?= 53
OBJDIR    ?= obj_dir
FILELIST  := files.f
SRCS      := $(filter %.sv,$(shell cat $(FILELIST)))
BINNAME   := V$(TOP)_s$(SEED)
BIN       := $(OBJDIR)/$(BINNAME)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST) Makefile
	$(VERILATOR) --binary --assert --top-module $(TOP) -GSeed=$(SEED) \
		-f $(FILELIST) -Mdir $(OBJDIR) -o $(BINNAME)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(OBJDIR)

// File: hazardTb.sv
module hazardTb import hazardPkg::*; #(
    parameter int Seed = 53
);

    localparam int HalfPeriod   = 50;
    localparam int ResetTimeout = 20;

    logic                 clk;
    logic                 rstN;
    logic [dataWidth-1:0] instr;
    logic [dataWidth-1:0] imm;
    logic [dataWidth-1:0] reg1Data;
    regAddrT              rd;
    logic                 regWrite;
    logic                 memEnable;
    logic [5:0]           forwards;
    logic                 nop;
    logic                 pcStall;

    // Reference history with slot 0 as ID
    regAddrT              mRd    [numStages];
    logic                 mWrite [numStages];
    logic                 mMem   [numStages];
    logic [dataWidth-1:0] mAddr  [numStages];
    logic                 mJbPending;

    // Expected results for the cycle under test
    logic [5:0] expFwd;
    logic       expRegHaz;
    logic       expMemHaz;
    logic       expNop;
    logic       expStall;
    logic       expJbNext;

    int memHazCount;
    int bubbleCount;

    // Base and offset values whose sums collide with and without wraparound
    logic [dataWidth-1:0] addrSet [4] = '{16'h0000, 16'h0010, 16'hFFF0, 16'h8000};

    hazardTop #(.DataWidth(dataWidth)) DUT (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .imm       (imm),
        .reg1Data  (reg1Data),
        .rd        (rd),
        .regWrite  (regWrite),
        .memEnable (memEnable),
        .forwards  (forwards),
        .nop       (nop),
        .pcStall   (pcStall)
    );

    always #HalfPeriod clk = ~clk;

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s expected %0h actual %0h", name, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "Value mismatch in %s", name);
        end
    endtask

    task automatic waitForReset();
        int cycles;
        cycles = 0;
        while (!rstN && cycles < ResetTimeout) begin
            @(posedge clk);
            cycles++;
        end
        if (!rstN) begin
            $display("Reset was never released");
            $display("SOME TESTS FAILED");
            $fatal(1, "Reset timeout");
        end
    endtask

    // Expected outputs from the current inputs and the reference history
    task automatic predict();
        regAddrT              rs;
        regAddrT              rt;
        logic                 isJr;
        logic                 isNop;
        logic [dataWidth-1:0] addr;
        logic                 rsHaz;
        logic                 rtHaz;
        rs = instr[10:8];
        rt = instr[7:5];
        isJr = instr[15:11] == opJr;
        isNop = instr[15:11] == opNop;
        addr = reg1Data + imm;
        expFwd = '0;
        expFwd[fwdExToExRs] = (mRd[0] == rs) && !mMem[0];
        expFwd[fwdExToExRt] = (mRd[0] == rt) && !mMem[0];
        expFwd[fwdMemToExRs] = mRd[1] == rs;
        expFwd[fwdMemToExRt] = mRd[1] == rt;
        expFwd[fwdExToIdRs] = (mRd[1] == rs) && !mMem[1] && isJr;
        expFwd[fwdMemToIdRs] = (mRd[2] == rs) && isJr;
        rsHaz = ((mRd[0] == rs) && ((mWrite[0] && !expFwd[fwdExToExRs]) || mMem[0]))
            || ((mRd[1] == rs) && (mWrite[1] || mMem[1]) && !expFwd[fwdMemToExRs]
                && !expFwd[fwdExToIdRs])
            || ((mRd[2] == rs) && mWrite[2] && !expFwd[fwdMemToIdRs])
            || ((mRd[3] == rs) && mWrite[3]);
        rtHaz = ((mRd[0] == rt) && ((mWrite[0] && !expFwd[fwdExToExRt]) || mMem[0]))
            || ((mRd[1] == rt) && mWrite[1] && !expFwd[fwdMemToExRt])
            || ((mRd[2] == rt) && mWrite[2])
            || ((mRd[3] == rt) && mWrite[3]);
        expRegHaz = rsHaz || rtHaz;
        expMemHaz = 1'b0;
        for (int k = 0; k < numStages; k++) begin
            if (memEnable && mMem[k] && mAddr[k] == addr) begin
                expMemHaz = 1'b1;
            end
        end
        expStall = (expRegHaz || expMemHaz) && !isNop;
        expNop = (expRegHaz || expMemHaz || mJbPending) && !isNop;
        expJbNext = ((instr[15:13] == opJumpHi) || (instr[15:13] == opBranchHi))
            && !expRegHaz && !expMemHaz;
    endtask

    task automatic advanceModel();
        for (int k = numStages - 1; k > 0; k--) begin
            mRd[k] = mRd[k-1];
            mWrite[k] = mWrite[k-1];
            mMem[k] = mMem[k-1];
            mAddr[k] = mAddr[k-1];
        end
        mRd[0] = rd;
        mWrite[0] = regWrite;
        mMem[0] = memEnable;
        mAddr[0] = reg1Data + imm;
        mJbPending = expJbNext;
    endtask

    task automatic applyCycle(input string name, input logic [dataWidth-1:0] instrV,
                              input logic [dataWidth-1:0] immV,
                              input logic [dataWidth-1:0] reg1V, input regAddrT rdV,
                              input logic rwV, input logic meV);
        @(negedge clk);
        instr = instrV;
        imm = immV;
        reg1Data = reg1V;
        rd = rdV;
        regWrite = rwV;
        memEnable = meV;
        // Sample shortly before the rising edge
        #(HalfPeriod - 10);
        predict();
        checkValue({name, " forwards"}, 32'(expFwd), 32'(forwards));
        checkValue({name, " nop"}, 32'(expNop), 32'(nop));
        checkValue({name, " pcStall"}, 32'(expStall), 32'(pcStall));
        if (expMemHaz) begin
            memHazCount++;
        end
        if (mJbPending && expNop) begin
            bubbleCount++;
        end
        @(posedge clk);
        advanceModel();
    endtask

    function automatic logic [dataWidth-1:0] makeInstr(input logic [4:0] op,
                                                       input regAddrT rs, input regAddrT rt);
        return {op, rs, rt, 5'($urandom)};
    endfunction

    // Percent biases pick the opcode class and memMix draws addresses from addrSet
    task automatic randomRun(input string name, input int count, input int jrBias,
                             input int jbBias, input int nopBias, input bit memMix);
        logic [4:0]           op;
        int                   pick;
        logic [dataWidth-1:0] immV;
        logic [dataWidth-1:0] baseV;
        for (int i = 0; i < count; i++) begin
            pick = int'($urandom_range(0, 99));
            if (pick < jrBias) begin
                op = opJr;
            end else if (pick < jrBias + jbBias) begin
                op = {($urandom_range(0, 1) == 0) ? opJumpHi : opBranchHi, 2'($urandom)};
            end else if (pick < jrBias + jbBias + nopBias) begin
                op = opNop;
            end else begin
                op = 5'($urandom);
            end
            if (memMix) begin
                immV = addrSet[$urandom_range(0, 3)];
                baseV = addrSet[$urandom_range(0, 3)];
            end else begin
                immV = 16'($urandom);
                baseV = 16'($urandom);
            end
            applyCycle(name, makeInstr(op, 3'($urandom_range(0, 2)), 3'($urandom_range(0, 2))),
                       immV, baseV, 3'($urandom_range(0, 2)), 1'($urandom),
                       1'($urandom));
        end
    endtask

    initial begin
        repeat (2) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

    initial begin
        void'($urandom(Seed));
        clk = 1'b0;
        rstN = 1'b0;
        instr = '0;
        imm = '0;
        reg1Data = '0;
        rd = '0;
        regWrite = 1'b0;
        memEnable = 1'b0;
        memHazCount = 0;
        bubbleCount = 0;
        mJbPending = 1'b0;
        expJbNext = 1'b0;
        for (int k = 0; k < numStages; k++) begin
            mRd[k] = '0;
            mWrite[k] = 1'b0;
            mMem[k] = 1'b0;
            mAddr[k] = '0;
        end

        waitForReset();

        applyCycle("reset", '0, '0, '0, '0, 1'b0, 1'b0);
        checkValue("reset nop", 0, 32'(expNop));
        checkValue("reset pcStall", 0, 32'(expStall));

        randomRun("regHazard", 300, 0, 0, 0, 1'b0);
        randomRun("jumpRegister", 200, 75, 0, 0, 1'b0);
        randomRun("memHazard", 300, 0, 0, 0, 1'b1);
        randomRun("branchJump", 200, 0, 40, 10, 1'b1);

        // Clean history before a jump with nothing in its way
        repeat (4) applyCycle("flush", makeInstr(5'b10000, 3'd5, 3'd6), '0, '0, 3'd7, 1'b0, 1'b0);
        applyCycle("jumpClean", makeInstr({opJumpHi, 2'b00}, 3'd1, 3'd2), '0, '0,
                   3'd7, 1'b0, 1'b0);
        applyCycle("afterJump", makeInstr(5'b10000, 3'd5, 3'd6), '0, '0, 3'd7, 1'b0, 1'b0);
        checkValue("bubble after clean jump", 1, 32'(expNop));

        // A load feeding the branch blocks it and no bubble follows
        applyCycle("load", makeInstr(5'b10000, 3'd5, 3'd6), '0, '0, 3'd3, 1'b1, 1'b1);
        applyCycle("branchStalled", makeInstr({opBranchHi, 2'b01}, 3'd3, 3'd5), '0, '0,
                   3'd7, 1'b0, 1'b0);
        checkValue("branch hazard", 1, 32'(expRegHaz));
        applyCycle("afterBranch", makeInstr(5'b10000, 3'd5, 3'd6), '0, '0, 3'd7, 1'b0, 1'b0);
        checkValue("no bubble after stalled branch", 0, 32'(expNop));

        // NOP reading a load result still raises no stall
        applyCycle("loadForNop", makeInstr(5'b10000, 3'd5, 3'd6), '0, '0, 3'd2, 1'b1, 1'b1);
        applyCycle("nopSuppress", makeInstr(opNop, 3'd2, 3'd2), '0, '0, 3'd7, 1'b0, 1'b0);
        checkValue("nop sees hazard", 1, 32'(expRegHaz));
        checkValue("nop suppressed", 0, 32'(expNop));
        randomRun("nopRun", 100, 0, 0, 80, 1'b1);

        checkValue("memory hazards seen", 1, 32'(memHazCount > 0));
        checkValue("bubbles seen", 1, 32'(bubbleCount > 0));
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// File: hazardTop.sv
module hazardTop import hazardPkg::*; #(
    parameter int DataWidth = dataWidth
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [dataWidth-1:0] instr,
    input  logic [DataWidth-1:0] imm,
    input  logic [DataWidth-1:0] reg1Data,
    input  regAddrT              rd,
    input  logic                 regWrite,
    input  logic                 memEnable,
    output logic [5:0]           forwards,
    output logic                 nop,
    output logic                 pcStall
);

    logic regHazard;
    logic memHazard;

    stageIf #(.DataWidth(DataWidth)) histIf ();

    pipeHistory #(.DataWidth(DataWidth)) history (
        .clk       (clk),
        .rstN      (rstN),
        .imm       (imm),
        .reg1Data  (reg1Data),
        .rd        (rd),
        .regWrite  (regWrite),
        .memEnable (memEnable),
        .hist      (histIf.producer)
    );

    regHazardUnit regUnit (
        .instr     (instr),
        .memEnable (memEnable),
        .hist      (histIf.consumer),
        .forwards  (forwards),
        .regHazard (regHazard)
    );

    memHazardUnit #(.DataWidth(DataWidth)) memUnit (
        .memEnable (memEnable),
        .hist      (histIf.consumer),
        .memHazard (memHazard)
    );

    issueControl issueCtl (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .regHazard (regHazard),
        .memHazard (memHazard),
        .nop       (nop),
        .pcStall   (pcStall)
    );

endmodule

// File: issueControl.sv
module issueControl import hazardPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [dataWidth-1:0] instr,
    input  logic                 regHazard,
    input  logic                 memHazard,
    output logic                 nop,
    output logic                 pcStall
);

    logic isNop;
    logic isJb;
    logic jbPending;
    logic anyHazard;

    assign isNop = instr[15:11] == opNop;
    assign isJb  = (instr[15:13] == opJumpHi) || (instr[15:13] == opBranchHi);

    assign anyHazard = regHazard | memHazard;

    // One bubble follows a jump or branch that actually issued
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            jbPending <= 1'b0;
        end else begin
            jbPending <= isJb & ~anyHazard;
        end
    end

    // A NOP in fetch needs neither a stall nor an inserted bubble
    assign pcStall = anyHazard & ~isNop;
    assign nop     = (anyHazard | jbPending) & ~isNop;

    assert property (@(posedge clk) disable iff (!rstN) pcStall |-> nop);

endmodule

// File: memHazardUnit.sv
module memHazardUnit import hazardPkg::*; #(
    parameter int DataWidth = dataWidth
) (
    input  logic     memEnable,
    stageIf.consumer hist,
    output logic     memHazard
);

    logic [DataWidth-1:0] addr;
    logic [numStages-1:0] slotHit;

    assign addr = hist.curAddr;

    // Each slot compares only when that slot itself touched memory
    always_comb begin
        for (int k = 0; k < numStages; k++) begin
            slotHit[k] = hist.memEnable[k] && (hist.memAddr[k] == addr);
        end
    end

    assign memHazard = memEnable & (|slotHit);

    always_comb begin
        // Only a memory access can collide
        assert (!memHazard || memEnable);
    end

endmodule

// File: regHazardUnit.sv
module regHazardUnit import hazardPkg::*; (
    input  logic [dataWidth-1:0] instr,
    input  logic                 memEnable,
    stageIf.consumer             hist,
    output logic [5:0]           forwards,
    output logic                 regHazard
);

    regAddrT              rs;
    regAddrT              rt;
    logic                 isJr;
    logic [numStages-1:0] rsMatch;
    logic [numStages-1:0] rtMatch;
    logic                 rsHazard;
    logic                 rtHazard;

    // Source fields of the instruction in fetch
    assign rs   = instr[10:8];
    assign rt   = instr[7:5];
    assign isJr = instr[15:11] == opJr;

    always_comb begin
        for (int k = 0; k < numStages; k++) begin
            rsMatch[k] = hist.rd[k] == rs;
            rtMatch[k] = hist.rd[k] == rt;
        end
    end

    // A load still in ID has no data to hand over yet
    assign forwards[fwdExToExRs]  = rsMatch[0] & ~hist.memEnable[0];
    assign forwards[fwdExToExRt]  = rtMatch[0] & ~hist.memEnable[0];
    assign forwards[fwdMemToExRs] = rsMatch[1];
    assign forwards[fwdMemToExRt] = rtMatch[1];

    // Paths into ID exist only for jump register
    assign forwards[fwdExToIdRs]  = rsMatch[1] & ~hist.memEnable[1] & isJr;
    assign forwards[fwdMemToIdRs] = rsMatch[2] & isJr;

    assign rsHazard =
        (rsMatch[0] & ((hist.regWrite[0] & ~forwards[fwdExToExRs]) | hist.memEnable[0])) |
        (rsMatch[1] & (hist.regWrite[1] | hist.memEnable[1]) &
            ~forwards[fwdMemToExRs] & ~forwards[fwdExToIdRs]) |
        (rsMatch[2] & hist.regWrite[2] & ~forwards[fwdMemToIdRs]) |
        (rsMatch[3] & hist.regWrite[3]);

    // WB is not forwarded for rt
    assign rtHazard =
        (rtMatch[0] & ((hist.regWrite[0] & ~forwards[fwdExToExRt]) | hist.memEnable[0])) |
        (rtMatch[1] & hist.regWrite[1] & ~forwards[fwdMemToExRt]) |
        (rtMatch[2] & hist.regWrite[2]) |
        (rtMatch[3] & hist.regWrite[3]);

    assign regHazard = rsHazard | rtHazard;

    always_comb begin
        // Forwarding into ID belongs to jump register alone
        assert (!(forwards[fwdExToIdRs] || forwards[fwdMemToIdRs]) || isJr);
    end

endmodule

// File: pipeHistory.sv
module pipeHistory import hazardPkg::*; #(
    parameter int DataWidth = dataWidth
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [DataWidth-1:0] imm,
    input  logic [DataWidth-1:0] reg1Data,
    input  regAddrT              rd,
    input  logic                 regWrite,
    input  logic                 memEnable,
    stageIf.producer             hist
);

    logic [DataWidth-1:0] addr;

    // Base plus offset with the carry out dropped so the sum wraps
    assign addr = reg1Data + imm;
    assign hist.curAddr = addr;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int k = 0; k < numStages; k++) begin
                hist.rd[k]        <= '0;
                hist.regWrite[k]  <= 1'b0;
                hist.memEnable[k] <= 1'b0;
                hist.memAddr[k]   <= '0;
            end
        end else begin
            // Fetch enters ID
            hist.rd[0]        <= rd;
            hist.regWrite[0]  <= regWrite;
            hist.memEnable[0] <= memEnable;
            hist.memAddr[0]   <= addr;

            // Older entries each move one slot further
            for (int k = 1; k < numStages; k++) begin
                hist.rd[k]        <= hist.rd[k-1];
                hist.regWrite[k]  <= hist.regWrite[k-1];
                hist.memEnable[k] <= hist.memEnable[k-1];
                hist.memAddr[k]   <= hist.memAddr[k-1];
            end
        end
    end

endmodule

// File: stageIf.sv
interface stageIf import hazardPkg::*; #(
    parameter int DataWidth = dataWidth
);

    // Per-slot record of the instructions ahead of the one in fetch
    regAddrT                rd        [numStages];
    logic                   regWrite  [numStages];
    logic                   memEnable [numStages];
    logic [DataWidth-1:0]   memAddr   [numStages];

    // Address of the instruction now in fetch
    logic [DataWidth-1:0]   curAddr;

    modport producer (
        output rd,
        output regWrite,
        output memEnable,
        output memAddr,
        output curAddr
    );

    modport consumer (
        input rd,
        input regWrite,
        input memEnable,
        input memAddr,
        input curAddr
    );

endinterface

// File: hazardPkg.sv
package hazardPkg;

    // Datapath and address width
    localparam int dataWidth = 16;

    // Eight architectural registers
    localparam int regAddrWidth = 3;

    // History slots: 0 is ID, 1 is EX, 2 is MEM, 3 is WB
    localparam int numStages = 4;

    // Full 5-bit opcodes
    localparam logic [4:0] opNop = 5'b00001;
    localparam logic [4:0] opJr  = 5'b00111;

    // 3-bit opcode prefixes for control transfers
    localparam logic [2:0] opJumpHi   = 3'b001;
    localparam logic [2:0] opBranchHi = 3'b011;

    // Bit positions in the forwards vector
    localparam int fwdExToExRs  = 5;
    localparam int fwdMemToExRs = 4;
    localparam int fwdExToExRt  = 3;
    localparam int fwdMemToExRt = 2;
    localparam int fwdExToIdRs  = 1;
    localparam int fwdMemToIdRs = 0;

    typedef logic [regAddrWidth-1:0] regAddrT;

endpackage
